// File: include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath and select widths
`define XLEN_W 64
`define SEL_W  34

// one-hot select bits for single-cycle ops
`define SEL_ADD    0
`define SEL_ADDW   1
`define SEL_SUB    2
`define SEL_SUBW   3
`define SEL_SLT    4
`define SEL_SLTU   5
`define SEL_AND    6
`define SEL_OR     7
`define SEL_XOR    8
`define SEL_SLL    9
`define SEL_SLLI   10
`define SEL_SLLIW  11
`define SEL_SLLW   12
`define SEL_SRL    13
`define SEL_SRLI   14
`define SEL_SRLIW  15
`define SEL_SRLW   16
`define SEL_SRA    17
`define SEL_SRAI   18
`define SEL_SRAIW  19
`define SEL_SRAW   20

// divider slice
`define SEL_REM    21
`define SEL_REMU   22
`define SEL_REMUW  23
`define SEL_REMW   24
`define SEL_DIV    25
`define SEL_DIVU   26
`define SEL_DIVUW  27
`define SEL_DIVW   28

// multiplier slice
`define SEL_MUL    29
`define SEL_MULH   30
`define SEL_MULHSU 31
`define SEL_MULHU  32
`define SEL_MULW   33

// unit slice bounds inside the select
`define DIV_SEL_LO 21
`define DIV_SEL_HI 28
`define MUL_SEL_LO 29
`define MUL_SEL_HI 33

// iterations per multicycle operation
`define MUL_ITER 64
`define DIV_ITER 64

`endif

// File: logic/alu_pkg.sv
`default_nettype none
`include "alu_config.svh"

package alu_pkg;

  // full register width operand or result
  typedef logic [`XLEN_W-1:0] word_t;

  // low half, used by the W-form ops
  typedef logic [`XLEN_W/2-1:0] half_t;

  // one-hot operation select
  typedef logic [`SEL_W-1:0] sel_t;

  // per-unit slices of the select
  typedef logic [`MUL_SEL_HI-`MUL_SEL_LO:0] mul_type_t;
  typedef logic [`DIV_SEL_HI-`DIV_SEL_LO:0] div_type_t;

  // shared FSM of the multiplier and the divider
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } unit_state_t;

  // W-form results are the low half sign-extended to full width
  function automatic word_t sext_half(half_t v);
    return {{(`XLEN_W/2){v[`XLEN_W/2-1]}}, v};
  endfunction

endpackage

`default_nettype wire

// File: logic/alu_multiplier.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_multiplier (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    mult_valid,
  input  wire alu_pkg::mul_type_t mult_type,
  input  wire alu_pkg::word_t    multiplicand,
  input  wire alu_pkg::word_t    multiplier,
  input  wire                    result_ready,
  output alu_pkg::word_t         mult_out,
  output logic                   mult_stall,
  output logic                   result_ok
);

  localparam int CNT_W    = $clog2(`MUL_ITER);
  localparam int MSB      = `XLEN_W - 1;
  localparam int I_MUL    = `SEL_MUL - `MUL_SEL_LO;
  localparam int I_MULH   = `SEL_MULH - `MUL_SEL_LO;
  localparam int I_MULHSU = `SEL_MULHSU - `MUL_SEL_LO;
  localparam int I_MULW   = `SEL_MULW - `MUL_SEL_LO;

  alu_pkg::unit_state_t state;
  logic [CNT_W-1:0]     cnt;

  // acc holds {partial product, remaining multiplier bits}
  logic [2*`XLEN_W-1:0] acc;
  alu_pkg::word_t       mcand;
  logic                 prod_neg;
  alu_pkg::mul_type_t   op_type;

  logic                 a_signed;
  logic                 b_signed;
  logic                 a_neg;
  logic                 b_neg;
  alu_pkg::word_t       a_mag;
  alu_pkg::word_t       b_mag;
  logic [`XLEN_W:0]     step_sum;
  logic [2*`XLEN_W-1:0] product;
  alu_pkg::word_t       out_sel;

  // mulh is signed x signed, mulhsu signed x unsigned
  always_comb begin
    a_signed = mult_type[I_MULH] | mult_type[I_MULHSU];
    b_signed = mult_type[I_MULH];
    a_neg    = a_signed & multiplicand[MSB];
    b_neg    = b_signed & multiplier[MSB];
    a_mag    = a_neg ? -multiplicand : multiplicand;
    b_mag    = b_neg ? -multiplier : multiplier;
  end

  // one shift-add step, lsb of acc decides the add
  assign step_sum = {1'b0, acc[2*`XLEN_W-1:`XLEN_W]} + {1'b0, (acc[0] ? mcand : '0)};

  assign product = prod_neg ? -acc : acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= alu_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        alu_pkg::IDLE: begin
          if (mult_valid) begin
            state <= alu_pkg::BUSY;
            cnt   <= '0;
          end
        end
        alu_pkg::BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(`MUL_ITER - 1)) begin
            state <= alu_pkg::DONE;
          end
        end
        alu_pkg::DONE: begin
          if (result_ready) begin
            state <= alu_pkg::IDLE;
          end
        end
        default: state <= alu_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == alu_pkg::IDLE && mult_valid) begin
      acc      <= {`XLEN_W'(0), b_mag};
      mcand    <= a_mag;
      prod_neg <= a_neg ^ b_neg;
      op_type  <= mult_type;
    end else if (state == alu_pkg::BUSY) begin
      acc <= {step_sum, acc[`XLEN_W-1:1]};
    end
  end

  // mulh, mulhsu and mulhu all take the high half
  always_comb begin
    if (op_type[I_MUL]) begin
      out_sel = product[`XLEN_W-1:0];
    end else if (op_type[I_MULW]) begin
      out_sel = alu_pkg::sext_half(product[`XLEN_W/2-1:0]);
    end else begin
      out_sel = product[2*`XLEN_W-1:`XLEN_W];
    end
  end

  // zero outside DONE so the ALU can OR both unit results
  assign mult_out   = (state == alu_pkg::DONE) ? out_sel : '0;
  assign result_ok  = (state == alu_pkg::DONE) & result_ready;
  assign mult_stall = mult_valid & ~result_ok;

endmodule

`default_nettype wire

// File: logic/alu_divider.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_divider (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    div_valid,
  input  wire alu_pkg::div_type_t div_type,
  input  wire alu_pkg::word_t    dividend,
  input  wire alu_pkg::word_t    divisor,
  input  wire                    result_ready,
  output alu_pkg::word_t         div_out,
  output logic                   div_stall,
  output logic                   result_ok
);

  localparam int CNT_W   = $clog2(`DIV_ITER);
  localparam int MSB     = `XLEN_W - 1;
  localparam int HW      = `XLEN_W / 2;
  localparam int I_REM   = `SEL_REM - `DIV_SEL_LO;
  localparam int I_REMU  = `SEL_REMU - `DIV_SEL_LO;
  localparam int I_REMUW = `SEL_REMUW - `DIV_SEL_LO;
  localparam int I_REMW  = `SEL_REMW - `DIV_SEL_LO;
  localparam int I_DIVU  = `SEL_DIVU - `DIV_SEL_LO;
  localparam int I_DIVUW = `SEL_DIVUW - `DIV_SEL_LO;
  localparam int I_DIVW  = `SEL_DIVW - `DIV_SEL_LO;

  alu_pkg::unit_state_t state;
  logic [CNT_W-1:0]     cnt;

  // iteration registers
  alu_pkg::word_t       rem;
  alu_pkg::word_t       quo;
  alu_pkg::word_t       dsor;
  logic                 q_neg;
  logic                 r_neg;
  logic                 rem_sel;
  logic                 word_sel;
  logic                 div_zero;

  logic                 is_word;
  logic                 is_uns;
  logic                 is_rem;
  alu_pkg::word_t       a_ext;
  alu_pkg::word_t       b_ext;
  logic                 a_neg;
  logic                 b_neg;
  alu_pkg::word_t       a_mag;
  alu_pkg::word_t       b_mag;
  logic [`XLEN_W:0]     shifted;
  logic [`XLEN_W:0]     diff;
  alu_pkg::word_t       q_fix;
  alu_pkg::word_t       r_fix;
  alu_pkg::word_t       raw;

  // operand prep, W forms widen the low half first
  always_comb begin
    is_word = div_type[I_REMUW] | div_type[I_REMW] | div_type[I_DIVUW] | div_type[I_DIVW];
    is_uns  = div_type[I_REMU] | div_type[I_REMUW] | div_type[I_DIVU] | div_type[I_DIVUW];
    is_rem  = div_type[I_REM] | div_type[I_REMU] | div_type[I_REMUW] | div_type[I_REMW];
    if (!is_word) begin
      a_ext = dividend;
      b_ext = divisor;
    end else if (is_uns) begin
      a_ext = {HW'(0), dividend[HW-1:0]};
      b_ext = {HW'(0), divisor[HW-1:0]};
    end else begin
      a_ext = alu_pkg::sext_half(dividend[HW-1:0]);
      b_ext = alu_pkg::sext_half(divisor[HW-1:0]);
    end
    a_neg = ~is_uns & a_ext[MSB];
    b_neg = ~is_uns & b_ext[MSB];
    a_mag = a_neg ? -a_ext : a_ext;
    b_mag = b_neg ? -b_ext : b_ext;
  end

  // restoring step, keep the trial difference when it does not go negative
  assign shifted = {rem, quo[MSB]};
  assign diff    = shifted - {1'b0, dsor};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= alu_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        alu_pkg::IDLE: begin
          if (div_valid) begin
            state <= alu_pkg::BUSY;
            cnt   <= '0;
          end
        end
        alu_pkg::BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(`DIV_ITER - 1)) begin
            state <= alu_pkg::DONE;
          end
        end
        alu_pkg::DONE: begin
          if (result_ready) begin
            state <= alu_pkg::IDLE;
          end
        end
        default: state <= alu_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == alu_pkg::IDLE && div_valid) begin
      rem      <= '0;
      quo      <= a_mag;
      dsor     <= b_mag;
      q_neg    <= a_neg ^ b_neg;
      r_neg    <= a_neg;
      rem_sel  <= is_rem;
      word_sel <= is_word;
      div_zero <= (b_ext == '0);
    end else if (state == alu_pkg::BUSY) begin
      rem <= diff[`XLEN_W] ? shifted[`XLEN_W-1:0] : diff[`XLEN_W-1:0];
      quo <= {quo[MSB-1:0], ~diff[`XLEN_W]};
    end
  end

  // quotient sign is the XOR of operand signs, remainder follows the dividend.
  // Signed overflow needs no special path: |min| / 1 gives min back with rem 0.
  // Divide by zero leaves rem = |dividend|, so only the quotient is forced.
  always_comb begin
    q_fix = q_neg ? -quo : quo;
    r_fix = r_neg ? -rem : rem;
    if (rem_sel) begin
      raw = r_fix;
    end else if (div_zero) begin
      raw = '1;
    end else begin
      raw = q_fix;
    end
  end

  assign div_out   = (state != alu_pkg::DONE) ? '0 :
                     word_sel ? alu_pkg::sext_half(raw[HW-1:0]) : raw;
  assign result_ok = (state == alu_pkg::DONE) & result_ready;
  assign div_stall = div_valid & ~result_ok;

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu (
  input  wire                 clk,
  input  wire                 rst,
  input  wire alu_pkg::word_t op_1,
  input  wire alu_pkg::word_t op_2,
  input  wire alu_pkg::sel_t  alu_sel,
  input  wire                 lsu_stall,
  output alu_pkg::word_t      result,
  output logic                alu_stall,
  output logic                alu_ok
);

  localparam int MSB    = `XLEN_W - 1;
  localparam int HW     = `XLEN_W / 2;
  localparam int N_COMB = `SEL_SRAW + 1;

  logic           subtract;
  logic           word_shift;
  logic           srl_word;
  logic           sra_word;
  logic [5:0]     shamt;
  alu_pkg::word_t op_2_in;
  alu_pkg::word_t sum;
  logic           slt_bit;
  logic           sltu_bit;
  alu_pkg::word_t srl_src;
  alu_pkg::word_t sra_src;
  alu_pkg::word_t sll_res;
  alu_pkg::word_t srl_res;
  alu_pkg::word_t sra_res;
  alu_pkg::word_t comb_res [N_COMB];

  logic           result_ready;
  alu_pkg::word_t mult_out;
  logic           mult_stall;
  logic           mult_ok;
  alu_pkg::word_t div_out;
  logic           div_stall;
  logic           div_ok;

  // shared adder, compares reuse the subtraction
  assign subtract = alu_sel[`SEL_SUB] | alu_sel[`SEL_SUBW] |
                    alu_sel[`SEL_SLT] | alu_sel[`SEL_SLTU];
  assign op_2_in  = subtract ? ~op_2 : op_2;
  assign sum      = op_1 + op_2_in + alu_pkg::word_t'(subtract);

  // same sign bits means the difference sign decides
  assign slt_bit  = (op_1[MSB] & ~op_2[MSB]) | ((op_1[MSB] == op_2[MSB]) & sum[MSB]);
  assign sltu_bit = (~op_1[MSB] & op_2[MSB]) | ((op_1[MSB] == op_2[MSB]) & sum[MSB]);

  // word shifts only use 5 bits of shamt
  assign word_shift = alu_sel[`SEL_SLLIW] | alu_sel[`SEL_SLLW] |
                      alu_sel[`SEL_SRLIW] | alu_sel[`SEL_SRLW] |
                      alu_sel[`SEL_SRAIW] | alu_sel[`SEL_SRAW];
  assign shamt      = {op_2[5] & ~word_shift, op_2[4:0]};

  // upper half refilled before word right shifts
  assign srl_word = alu_sel[`SEL_SRLIW] | alu_sel[`SEL_SRLW];
  assign sra_word = alu_sel[`SEL_SRAIW] | alu_sel[`SEL_SRAW];
  assign srl_src  = srl_word ? {HW'(0), op_1[HW-1:0]} : op_1;
  assign sra_src  = sra_word ? alu_pkg::sext_half(op_1[HW-1:0]) : op_1;

  assign sll_res = op_1 << shamt;
  assign srl_res = srl_src >> shamt;
  assign sra_res = $signed(sra_src) >>> shamt;

  // result table, indexed by select bit
  assign comb_res[`SEL_ADD]   = sum;
  assign comb_res[`SEL_ADDW]  = alu_pkg::sext_half(sum[HW-1:0]);
  assign comb_res[`SEL_SUB]   = sum;
  assign comb_res[`SEL_SUBW]  = alu_pkg::sext_half(sum[HW-1:0]);
  assign comb_res[`SEL_SLT]   = alu_pkg::word_t'(slt_bit);
  assign comb_res[`SEL_SLTU]  = alu_pkg::word_t'(sltu_bit);
  assign comb_res[`SEL_AND]   = op_1 & op_2;
  assign comb_res[`SEL_OR]    = op_1 | op_2;
  assign comb_res[`SEL_XOR]   = op_1 ^ op_2;
  assign comb_res[`SEL_SLL]   = sll_res;
  assign comb_res[`SEL_SLLI]  = sll_res;
  assign comb_res[`SEL_SLLIW] = alu_pkg::sext_half(sll_res[HW-1:0]);
  assign comb_res[`SEL_SLLW]  = alu_pkg::sext_half(sll_res[HW-1:0]);
  assign comb_res[`SEL_SRL]   = srl_res;
  assign comb_res[`SEL_SRLI]  = srl_res;
  assign comb_res[`SEL_SRLIW] = alu_pkg::sext_half(srl_res[HW-1:0]);
  assign comb_res[`SEL_SRLW]  = alu_pkg::sext_half(srl_res[HW-1:0]);
  assign comb_res[`SEL_SRA]   = sra_res;
  assign comb_res[`SEL_SRAI]  = sra_res;
  assign comb_res[`SEL_SRAIW] = alu_pkg::sext_half(sra_res[HW-1:0]);
  assign comb_res[`SEL_SRAW]  = alu_pkg::sext_half(sra_res[HW-1:0]);

  // one-hot and-or mux, unit results when no single-cycle bit is set
  always_comb begin
    result = mult_out | div_out;
    if (|alu_sel[N_COMB-1:0]) begin
      result = '0;
      for (int i = 0; i < N_COMB; i++) begin
        if (alu_sel[i]) begin
          result = result | comb_res[i];
        end
      end
    end
  end

  assign result_ready = ~lsu_stall;

  alu_multiplier u_multiplier (
    .clk          (clk),
    .rst          (rst),
    .mult_valid   (|alu_sel[`MUL_SEL_HI:`MUL_SEL_LO]),
    .mult_type    (alu_sel[`MUL_SEL_HI:`MUL_SEL_LO]),
    .multiplicand (op_1),
    .multiplier   (op_2),
    .result_ready (result_ready),
    .mult_out     (mult_out),
    .mult_stall   (mult_stall),
    .result_ok    (mult_ok)
  );

  alu_divider u_divider (
    .clk          (clk),
    .rst          (rst),
    .div_valid    (|alu_sel[`DIV_SEL_HI:`DIV_SEL_LO]),
    .div_type     (alu_sel[`DIV_SEL_HI:`DIV_SEL_LO]),
    .dividend     (op_1),
    .divisor      (op_2),
    .result_ready (result_ready),
    .div_out      (div_out),
    .div_stall    (div_stall),
    .result_ok    (div_ok)
  );

  assign alu_stall = mult_stall | div_stall;
  assign alu_ok    = mult_ok | div_ok;

endmodule

`default_nettype wire

// File: dv/alu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module alu_properties (
  input wire                       clk,
  input wire                       rst,
  input wire                       lsu_stall,
  input wire                       alu_ok,
  input wire                       mult_stall,
  input wire                       mult_ok,
  input wire                       div_stall,
  input wire                       div_ok,
  input wire alu_pkg::word_t       mult_out,
  input wire alu_pkg::word_t       div_out,
  input wire alu_pkg::unit_state_t mult_state,
  input wire alu_pkg::unit_state_t div_state
);

  // no done strobe while an iteration is still running
  no_ok_while_busy: assert property (@(posedge clk) disable iff (rst)
    alu_ok |-> (mult_state != alu_pkg::BUSY) && (div_state != alu_pkg::BUSY))
    else $error("alu_ok high while a unit is busy");

  ok_needs_ready: assert property (@(posedge clk) disable iff (rst)
    alu_ok |-> !lsu_stall)
    else $error("alu_ok high while lsu_stall is high");

  mult_stall_ok_excl: assert property (@(posedge clk) disable iff (rst)
    !(mult_stall && mult_ok))
    else $error("multiplier stall and done high together");

  div_stall_ok_excl: assert property (@(posedge clk) disable iff (rst)
    !(div_stall && div_ok))
    else $error("divider stall and done high together");

  // result held for as long as the unit sits in DONE
  mult_done_stable: assert property (@(posedge clk) disable iff (rst)
    (mult_state == alu_pkg::DONE) |=> (mult_state != alu_pkg::DONE) || $stable(mult_out))
    else $error("multiplier result changed in DONE");

  div_done_stable: assert property (@(posedge clk) disable iff (rst)
    (div_state == alu_pkg::DONE) |=> (div_state != alu_pkg::DONE) || $stable(div_out))
    else $error("divider result changed in DONE");

endmodule

bind alu alu_properties props_i (
  .clk        (clk),
  .rst        (rst),
  .lsu_stall  (lsu_stall),
  .alu_ok     (alu_ok),
  .mult_stall (mult_stall),
  .mult_ok    (mult_ok),
  .div_stall  (div_stall),
  .div_ok     (div_ok),
  .mult_out   (mult_out),
  .div_out    (div_out),
  .mult_state (u_multiplier.state),
  .div_state  (u_divider.state)
);

`default_nettype wire

// File: dv/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_tb;

  localparam int COMB_ROUNDS = 8;
  localparam int MUL_REP     = 3;
  localparam int DIV_REP     = 4;
  localparam int BP_OPS      = 4;
  localparam int UNIT_LAT    = `MUL_ITER + 2;
  localparam int N_OPS       = COMB_ROUNDS * (`SEL_SRAW + 1) +
                               MUL_REP * (`MUL_SEL_HI - `MUL_SEL_LO + 1) +
                               DIV_REP * (`DIV_SEL_HI - `DIV_SEL_LO + 1) + BP_OPS;
  localparam int MAX_CYCLES  = N_OPS * 70 + 200;
  localparam int MODE_NONE   = 0;
  localparam int MODE_COMB   = 1;
  localparam int MODE_UNIT   = 2;
  localparam int MODE_IDLE   = 3;

  logic           clk;
  logic           rst;
  alu_pkg::word_t op_1;
  alu_pkg::word_t op_2;
  alu_pkg::sel_t  alu_sel;
  logic           lsu_stall;
  alu_pkg::word_t result;
  logic           alu_stall;
  logic           alu_ok;

  // shared between the driver and the compare process
  int             mode = MODE_NONE;
  alu_pkg::word_t exp_val;
  string          op_label;
  int             exp_lat;
  int             lat_cnt;
  bit             unit_done;
  int             check_cnt = 0;
  int             err_cnt = 0;
  int             cycle_cnt = 0;
  logic [5:0]     shamt_corner [3] = '{6'd31, 6'd32, 6'd63};

  alu dut_i (
    .clk       (clk),
    .rst       (rst),
    .op_1      (op_1),
    .op_2      (op_2),
    .alu_sel   (alu_sel),
    .lsu_stall (lsu_stall),
    .result    (result),
    .alu_stall (alu_stall),
    .alu_ok    (alu_ok)
  );

  always #4 clk = ~clk;

  // expected result straight from the RV64IM rules
  function automatic alu_pkg::word_t alu_model(alu_pkg::sel_t sel, alu_pkg::word_t a,
                                               alu_pkg::word_t b);
    int             op;
    bit             w;
    logic [127:0]   p;
    alu_pkg::half_t aw;
    alu_pkg::half_t bw;
    alu_pkg::half_t r32;
    alu_pkg::word_t r;
    op = -1;
    aw = a[31:0];
    bw = b[31:0];
    r32 = '0;
    r = '0;
    p = '0;
    for (int i = 0; i < `SEL_W; i++) begin
      if (sel[i]) op = i;
    end
    // W forms give 32 bits that are sign-extended at the end
    w = op inside {`SEL_ADDW, `SEL_SUBW, `SEL_SLLW, `SEL_SLLIW, `SEL_SRLW, `SEL_SRLIW,
                   `SEL_SRAW, `SEL_SRAIW, `SEL_MULW, `SEL_DIVW, `SEL_DIVUW, `SEL_REMW,
                   `SEL_REMUW};
    case (op)
      `SEL_ADD:                r = a + b;
      `SEL_SUB:                r = a - b;
      `SEL_SLT:                r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      `SEL_SLTU:               r = (a < b) ? 64'd1 : 64'd0;
      `SEL_AND:                r = a & b;
      `SEL_OR:                 r = a | b;
      `SEL_XOR:                r = a ^ b;
      `SEL_SLL, `SEL_SLLI:     r = a << b[5:0];
      `SEL_SRL, `SEL_SRLI:     r = a >> b[5:0];
      `SEL_SRA, `SEL_SRAI:     r = $signed(a) >>> b[5:0];
      `SEL_ADDW:               r32 = aw + bw;
      `SEL_SUBW:               r32 = aw - bw;
      `SEL_SLLW, `SEL_SLLIW:   r32 = aw << b[4:0];
      `SEL_SRLW, `SEL_SRLIW:   r32 = aw >> b[4:0];
      `SEL_SRAW, `SEL_SRAIW:   r32 = $signed(aw) >>> b[4:0];
      `SEL_MUL:                r = a * b;
      `SEL_MULH: begin
        p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
        r = p[127:64];
      end
      `SEL_MULHSU: begin
        p = {{64{a[63]}}, a} * {64'd0, b};
        r = p[127:64];
      end
      `SEL_MULHU: begin
        p = {64'd0, a} * {64'd0, b};
        r = p[127:64];
      end
      `SEL_MULW:               r32 = aw * bw;
      `SEL_DIV: begin
        if (b == '0) r = '1;
        else if (a == 64'h8000_0000_0000_0000 && b == '1) r = a;
        else r = $signed(a) / $signed(b);
      end
      `SEL_DIVU:               r = (b == '0) ? '1 : a / b;
      `SEL_REM: begin
        if (b == '0) r = a;
        else if (a == 64'h8000_0000_0000_0000 && b == '1) r = '0;
        else r = $signed(a) % $signed(b);
      end
      `SEL_REMU:               r = (b == '0) ? a : a % b;
      `SEL_DIVW: begin
        if (bw == '0) r32 = '1;
        else if (aw == 32'h8000_0000 && bw == '1) r32 = aw;
        else r32 = $signed(aw) / $signed(bw);
      end
      `SEL_DIVUW:              r32 = (bw == '0) ? '1 : aw / bw;
      `SEL_REMW: begin
        if (bw == '0) r32 = aw;
        else if (aw == 32'h8000_0000 && bw == '1) r32 = '0;
        else r32 = $signed(aw) % $signed(bw);
      end
      `SEL_REMUW:              r32 = (bw == '0) ? aw : aw % bw;
      default:                 r = '0;
    endcase
    if (w) r = {{32{r32[31]}}, r32};
    return r;
  endfunction

  // mostly random with a share of edge values
  function automatic alu_pkg::word_t pick_operand();
    case ($urandom_range(0, 9))
      0:       return '0;
      1:       return '1;
      2:       return 64'h8000_0000_0000_0000;
      3:       return {$urandom, 32'h8000_0000};
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic bit is_word_div(int idx);
    return idx == `SEL_REMUW || idx == `SEL_REMW || idx == `SEL_DIVUW || idx == `SEL_DIVW;
  endfunction

  task automatic apply_op(int idx, alu_pkg::word_t a, alu_pkg::word_t b);
    op_1 = a;
    op_2 = b;
    alu_sel = '0;
    alu_sel[idx] = 1'b1;
    exp_val = alu_model(alu_sel, a, b);
    op_label = $sformatf("sel %0d a=%h b=%h", idx, a, b);
  endtask

  task automatic run_comb(int idx, alu_pkg::word_t a, alu_pkg::word_t b);
    @(negedge clk);
    apply_op(idx, a, b);
    mode = MODE_COMB;
  endtask

  // hold > 0 keeps lsu_stall high for that many cycles after the select
  task automatic run_unit(int idx, alu_pkg::word_t a, alu_pkg::word_t b, int hold);
    @(negedge clk);
    apply_op(idx, a, b);
    exp_lat = (hold > 0) ? hold + 1 : UNIT_LAT;
    lat_cnt = 0;
    unit_done = 1'b0;
    mode = MODE_UNIT;
    lsu_stall = (hold > 0);
    if (hold > 0) begin
      repeat (hold) @(negedge clk);
      lsu_stall = 1'b0;
    end
    while (!unit_done) @(negedge clk);
    alu_sel = '0;
    mode = MODE_IDLE;
  endtask

  task automatic report_test(string name, int checks_before, int errs_before);
    $display("test %s finished: %0d checks, %0d errors", name,
             check_cnt - checks_before, err_cnt - errs_before);
  endtask

  // compare process sampling on the rising edge
  always @(posedge clk) begin
    if (mode == MODE_COMB) begin
      check_cnt++;
      if (result !== exp_val) begin
        err_cnt++;
        $display("FAILED time=%0t %s: got %h, expected %h", $time, op_label, result, exp_val);
      end
      if (alu_stall || alu_ok) begin
        err_cnt++;
        $display("alu_stall or alu_ok went high on a single-cycle op at time %0t", $time);
      end
    end else if (mode == MODE_UNIT && !unit_done) begin
      lat_cnt++;
      if (alu_ok) begin
        check_cnt++;
        unit_done = 1'b1;
        if (result !== exp_val) begin
          err_cnt++;
          $display("FAILED time=%0t %s: got %h, expected %h", $time, op_label, result, exp_val);
        end
        if (lat_cnt != exp_lat) begin
          err_cnt++;
          $display("alu_ok came after %0d cycles instead of %0d at time %0t",
                   lat_cnt, exp_lat, $time);
        end
      end else if (!alu_stall) begin
        err_cnt++;
        $display("alu_stall dropped before the result was taken at time %0t", $time);
      end
    end else if (mode == MODE_IDLE) begin
      check_cnt++;
      if (alu_stall || alu_ok) begin
        err_cnt++;
        $display("alu_stall or alu_ok high with an idle select at time %0t", $time);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    int             idx;
    int             hold;
    int             c0;
    int             e0;
    alu_pkg::word_t a;
    alu_pkg::word_t b;
    clk = 1'b0;
    rst = 1'b1;
    op_1 = '0;
    op_2 = '0;
    alu_sel = '0;
    lsu_stall = 1'b0;
    void'($urandom(5543));
    repeat (4) @(negedge clk);
    rst = 1'b0;

    c0 = check_cnt;
    e0 = err_cnt;
    mode = MODE_IDLE;
    repeat (3) @(negedge clk);
    report_test("idle after reset", c0, e0);

    c0 = check_cnt;
    e0 = err_cnt;
    for (int r = 0; r < COMB_ROUNDS; r++) begin
      for (int i = 0; i <= `SEL_SRAW; i++) begin
        a = pick_operand();
        b = pick_operand();
        // first rounds pin the shift amount
        if (r < 3) b[5:0] = shamt_corner[r];
        run_comb(i, a, b);
      end
    end
    @(negedge clk);
    alu_sel = '0;
    mode = MODE_IDLE;
    report_test("single-cycle ops", c0, e0);

    c0 = check_cnt;
    e0 = err_cnt;
    for (int i = `MUL_SEL_LO; i <= `MUL_SEL_HI; i++) begin
      for (int n = 0; n < MUL_REP; n++) begin
        run_unit(i, pick_operand(), pick_operand(), 0);
      end
    end
    report_test("multiply", c0, e0);

    c0 = check_cnt;
    e0 = err_cnt;
    for (int i = `DIV_SEL_LO; i <= `DIV_SEL_HI; i++) begin
      for (int n = 0; n < DIV_REP; n++) begin
        a = pick_operand();
        b = pick_operand();
        if (n == 0) begin
          b = is_word_div(i) ? {$urandom, 32'h0} : '0;
        end else if (n == 1) begin
          // signed overflow from the most negative value over minus one
          a = is_word_div(i) ? {$urandom, 32'h8000_0000} : 64'h8000_0000_0000_0000;
          b = is_word_div(i) ? {$urandom, 32'hffff_ffff} : '1;
        end
        run_unit(i, a, b, 0);
      end
    end
    report_test("divide and remainder", c0, e0);

    c0 = check_cnt;
    e0 = err_cnt;
    for (int n = 0; n < BP_OPS; n++) begin
      idx = (n % 2 == 0) ? $urandom_range(`MUL_SEL_LO, `MUL_SEL_HI) :
                           $urandom_range(`DIV_SEL_LO, `DIV_SEL_HI);
      hold = UNIT_LAT - 1 + $urandom_range(1, 8);
      run_unit(idx, pick_operand(), pick_operand(), hold);
    end
    @(negedge clk);
    report_test("back-pressure", c0, e0);

    $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/alu_pkg.sv
logic/alu_multiplier.sv
logic/alu_divider.sv
logic/alu.sv
dv/alu_properties.sv
dv/alu_tb.sv

// File: run.sh
#!/bin/sh
# build the ALU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module alu_tb -f list.f -o alu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/alu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '>>> PASS'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
